//--- filelist.f
source/csr_pkg.sv
source/csr_access_ctrl.sv
source/csr_trap_regs.sv
source/csr_irq_regs.sv
source/csr_counters.sv
source/csr_file.sv
dv/tb_csr_file.sv

//--- run.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing -f filelist.f --top-module tb_csr_file -o sim_csr_file \
  > build.log 2>&1 || { cat build.log; echo "build failed"; exit 1; }
./obj_dir/sim_csr_file > sim.log 2>&1
cat sim.log
grep -q "TEST FAILED" sim.log && { echo "simulation failed"; exit 1; }
grep -q "TEST PASSED" sim.log || { echo "simulation did not finish"; exit 1; }
echo "simulation passed"
exit 0

//--- dv/tb_csr_file.sv
// --------------------------------------------------------------------
// CSR file testbench
// random accesses, traps, interrupts and counters against a model
// --------------------------------------------------------------------
`timescale 1ns/1ns

module tb_csr_file;

  import csr_pkg::*;

  localparam int unsigned MAX_CYCLES = 20000;
  localparam logic [31:0] IE_MASK    = 32'h7FFF_0888;

  logic clk_i, rst_ni, csr_mtvec_init_i, csr_access_i, instr_new_i;
  logic [31:0] hart_id_i, boot_addr_i, csr_wdata_i, pc_id_i, csr_mtval_i;
  csr_addr_e csr_addr_i;
  csr_op_e csr_op_i;
  logic csr_save_cause_i, csr_restore_mret_i, instr_ret_i;
  logic [5:0] csr_mcause_i;
  logic irq_software_i, irq_timer_i, irq_external_i;
  logic [14:0] irq_fast_i, csr_mfip_o;
  logic [31:0] csr_rdata_o, csr_mepc_o, csr_mtvec_o;
  logic illegal_csr_insn_o, csr_mstatus_mie_o, csr_mstatus_tw_o;
  logic csr_msip_o, csr_mtip_o, csr_meip_o, irq_pending_o;
  priv_lvl_e priv_lvl_o;

  // reference model state
  logic m_mie, m_mpie, m_tw;
  logic [1:0] m_mpp, m_priv;
  logic [31:0] m_mscratch, m_mepc, m_mtval, m_mtvec, m_ie;
  logic [5:0] m_mcause;
  logic [63:0] m_cycle, m_instret;
  logic [2:0] m_inh;
  // effects of the current cycle, applied at the next edge
  logic p_we, p_save, p_mret, p_ret, p_init, init_req;
  logic [11:0] p_addr;
  logic [31:0] p_wdata, p_pc, p_tval;
  logic [5:0] p_cause;

  csr_file i_csr_file (.*);

  initial begin
    clk_i = 1'b0;
    forever #50 clk_i = ~clk_i;
  end

  task automatic fail(input string msg);
    $display("%s", msg);
    $display("*** TEST FAILED ***");
    $fatal(1);
  endtask

  task automatic check_val(input string name, input logic [31:0] exp, input logic [31:0] act);
    assert (exp === act) else begin
      fail($sformatf("ERR %s expected %08h actual %08h", name, exp, act));
    end
  endtask

  function automatic logic csr_exists(input logic [11:0] a);
    case (a)
      MSTATUS, MISA, MIE, MTVEC, MCOUNTINHIBIT, MSCRATCH, MEPC, MCAUSE,
      MTVAL, MIP, MCYCLE, MINSTRET, MCYCLEH, MINSTRETH, MHARTID: return 1'b1;
      default: return 1'b0;
    endcase
  endfunction

  function automatic logic [31:0] irq_word();
    return {1'b0, irq_fast_i, 4'b0, irq_external_i, 3'b0, irq_timer_i, 3'b0,
            irq_software_i, 3'b0};
  endfunction

  function automatic logic [31:0] model_read(input logic [11:0] a);
    case (a)
      MSTATUS:       return (32'(m_mie) << 3) | (32'(m_mpie) << 7) | (32'(m_mpp) << 11)
                            | (32'(m_tw) << 21);
      MISA:          return MISA_VALUE;
      MIE:           return m_ie;
      MTVEC:         return m_mtvec;
      MCOUNTINHIBIT: return {29'b0, m_inh};
      MSCRATCH:      return m_mscratch;
      MEPC:          return m_mepc;
      MCAUSE:        return {m_mcause[5], 26'b0, m_mcause[4:0]};
      MTVAL:         return m_mtval;
      MIP:           return m_ie & irq_word();
      MCYCLE:        return m_cycle[31:0];
      MCYCLEH:       return m_cycle[63:32];
      MINSTRET:      return m_instret[31:0];
      MINSTRETH:     return m_instret[63:32];
      MHARTID:       return hart_id_i;
      default:       return 32'h0;
    endcase
  endfunction

  // advance the model by one clock edge
  task automatic model_edge();
    logic o_mie, o_mpie;
    logic [1:0] o_mpp, o_priv;
    logic [2:0] o_inh;
    o_mie = m_mie;
    o_mpie = m_mpie;
    o_mpp = m_mpp;
    o_priv = m_priv;
    o_inh = m_inh;
    if (p_we && p_addr == MCYCLE) m_cycle[31:0] = p_wdata;
    else if (p_we && p_addr == MCYCLEH) m_cycle[63:32] = p_wdata;
    else if (!o_inh[0]) m_cycle = m_cycle + 64'd1;
    if (p_we && p_addr == MINSTRET) m_instret[31:0] = p_wdata;
    else if (p_we && p_addr == MINSTRETH) m_instret[63:32] = p_wdata;
    else if (p_ret && !o_inh[2]) m_instret = m_instret + 64'd1;
    if (p_init) m_mtvec = {boot_addr_i[31:8], 8'h01};
    if (p_we) begin
      case (p_addr)
        MSTATUS: begin
          m_mie = p_wdata[3];
          m_mpie = p_wdata[7];
          m_mpp = (p_wdata[12:11] == 2'b00) ? 2'b00 : 2'b11;
          m_tw = p_wdata[21];
        end
        MIE:           m_ie = p_wdata & IE_MASK;
        MTVEC:         m_mtvec = {p_wdata[31:8], 8'h01};
        MCOUNTINHIBIT: m_inh = {p_wdata[2], 1'b0, p_wdata[0]};
        MSCRATCH:      m_mscratch = p_wdata;
        MEPC:          m_mepc = p_wdata & ~32'h1;
        MCAUSE:        m_mcause = {p_wdata[31], p_wdata[4:0]};
        MTVAL:         m_mtval = p_wdata;
        default: ;
      endcase
    end
    if (p_save) begin
      m_priv = 2'b11;
      m_mpie = o_mie;
      m_mpp = o_priv;
      m_mie = 1'b0;
      m_mepc = p_pc;
      m_mcause = p_cause;
      m_mtval = p_tval;
    end else if (p_mret) begin
      m_priv = o_mpp;
      m_mie = o_mpie;
      m_mpie = 1'b1;
      m_mpp = 2'b00;
    end
  endtask

  task automatic check_outputs();
    logic [11:0] a;
    logic [31:0] r, w;
    logic ill;
    a = csr_addr_i;
    r = model_read(a);
    ill = csr_access_i & (!csr_exists(a) | (a[9:8] > m_priv)
          | ((a[11:10] == 2'b11) & (csr_op_i != READ)));
    check_val("csr_rdata_o", r, csr_rdata_o);
    check_val("illegal_csr_insn_o", 32'(ill), 32'(illegal_csr_insn_o));
    check_val("priv_lvl_o", 32'(m_priv), 32'(priv_lvl_o));
    check_val("csr_mstatus_mie_o", 32'(m_mie), 32'(csr_mstatus_mie_o));
    check_val("csr_mstatus_tw_o", 32'(m_tw), 32'(csr_mstatus_tw_o));
    check_val("csr_mepc_o", m_mepc, csr_mepc_o);
    check_val("csr_mtvec_o", m_mtvec, csr_mtvec_o);
    check_val("csr_mip", m_ie & irq_word(), {1'b0, csr_mfip_o, 4'b0, csr_meip_o, 3'b0,
              csr_mtip_o, 3'b0, csr_msip_o, 3'b0});
    check_val("irq_pending_o", 32'(|(m_ie & irq_word())), 32'(irq_pending_o));
    case (csr_op_i)
      SET:     w = csr_wdata_i | r;
      CLEAR:   w = ~csr_wdata_i & r;
      default: w = csr_wdata_i;
    endcase
    p_we = csr_access_i & instr_new_i & (csr_op_i != READ) & !ill;
    p_addr = a;
    p_wdata = w;
    p_save = csr_save_cause_i;
    p_mret = csr_restore_mret_i;
    p_ret = instr_ret_i;
    p_init = csr_mtvec_init_i;
    p_pc = pc_id_i;
    p_cause = csr_mcause_i;
    p_tval = csr_mtval_i;
  endtask

  // one clock cycle of stimulus, checked at the falling edge
  task automatic step(input logic acc, input logic nw, input logic [11:0] a,
                      input logic [1:0] op, input logic [31:0] wd, input logic sv,
                      input logic mr, input logic ret);
    logic [31:0] r;
    @(posedge clk_i);
    model_edge();
    r = $urandom;
    csr_access_i <= acc;
    instr_new_i <= nw;
    csr_addr_i <= csr_addr_e'(a);
    csr_op_i <= csr_op_e'(op);
    csr_wdata_i <= wd;
    csr_save_cause_i <= sv;
    csr_restore_mret_i <= mr;
    instr_ret_i <= ret;
    csr_mtvec_init_i <= init_req;
    irq_software_i <= r[0];
    irq_timer_i <= r[1];
    irq_external_i <= r[2];
    irq_fast_i <= r[31:17];
    pc_id_i <= $urandom;
    csr_mtval_i <= $urandom;
    r = $urandom;
    csr_mcause_i <= r[5:0];
    init_req = 1'b0;
    @(negedge clk_i);
    check_outputs();
  endtask

  task automatic access(input logic [11:0] a, input logic [1:0] op, input logic [31:0] wd);
    step(1'b1, 1'b1, a, op, wd, 1'b0, 1'b0, 1'b0);
  endtask

  task automatic idle(input logic [11:0] a, input logic ret);
    step(1'b0, 1'b0, a, 2'b00, 32'h0, 1'b0, 1'b0, ret);
  endtask

  initial begin
    for (int cyc = 0; cyc < MAX_CYCLES; cyc++) @(posedge clk_i);
    $display("simulation ran past its cycle limit without finishing");
    $display("*** TEST FAILED ***");
    $fatal(1);
  end

  initial begin
    logic [11:0] trap_addrs [7];
    logic [31:0] r, v0, v1;
    int n, k, rets;
    void'($urandom(32'hacfea998));
    trap_addrs = '{MSTATUS, MIE, MSCRATCH, MEPC, MCAUSE, MTVAL, MTVEC};
    rst_ni = 1'b0;
    {csr_mtvec_init_i, csr_access_i, instr_new_i, csr_save_cause_i} = '0;
    {csr_restore_mret_i, instr_ret_i, irq_software_i, irq_timer_i} = '0;
    {irq_external_i, irq_fast_i, csr_mcause_i} = '0;
    {csr_wdata_i, pc_id_i, csr_mtval_i} = '0;
    csr_addr_i = MSTATUS;
    csr_op_i = READ;
    hart_id_i = $urandom;
    boot_addr_i = $urandom;
    {m_mie, m_tw, m_mpp, m_mcause, m_inh} = '0;
    {m_mscratch, m_mepc, m_mtval, m_ie, m_cycle, m_instret} = '0;
    m_mpie = 1'b1;
    m_priv = 2'b11;
    m_mtvec = 32'h1;
    {p_we, p_save, p_mret, p_ret, p_init, init_req, p_addr, p_wdata} = '0;
    {p_pc, p_tval, p_cause} = '0;
    repeat (3) @(posedge clk_i);
    rst_ni <= 1'b1;

    // reset values
    access(MSTATUS, READ, 32'h0);
    check_val("mstatus", 32'h80, csr_rdata_o);
    access(MTVEC, READ, 32'h0);
    check_val("mtvec", 32'h1, csr_rdata_o);
    access(MIE, READ, 32'h0);
    access(MISA, READ, 32'h0);
    access(MHARTID, READ, 32'h0);
    init_req = 1'b1;
    idle(MTVEC, 1'b0);
    n = 0;
    while (csr_mtvec_o !== {boot_addr_i[31:8], 8'h01} && n < 10) begin
      idle(MTVEC, 1'b0);
      n++;
    end
    if (n >= 10) fail("mtvec never loaded the boot address");

    // random accesses to the trap and interrupt CSRs
    for (int i = 0; i < 400; i++) begin
      r = $urandom;
      step(1'b1, r[3:0] != 4'h0, trap_addrs[r[10:8] % 7], r[5:4], $urandom,
           1'b0, 1'b0, r[6]);
      access(trap_addrs[r[10:8] % 7], READ, 32'h0);
    end

    // illegal accesses
    for (int i = 0; i < 40; i++) begin
      r = $urandom;
      while (csr_exists(r[11:0])) r = $urandom;
      access(r[11:0], r[13:12], $urandom);
      check_val("illegal_csr_insn_o", 32'h1, 32'(illegal_csr_insn_o));
      r = $urandom;
      access(MHARTID, (r[1:0] == 2'b00) ? 2'b01 : r[1:0], $urandom);
      check_val("illegal_csr_insn_o", 32'h1, 32'(illegal_csr_insn_o));
    end

    // trap entry, MRET and user mode
    for (int i = 0; i < 20; i++) begin
      step(1'b0, 1'b0, MEPC, 2'b00, 32'h0, 1'b1, 1'b0, 1'b0);
      step(1'b0, 1'b0, MCAUSE, 2'b00, 32'h0, 1'b0, 1'b1, 1'b0);
      r = $urandom;
      access(MSTATUS, WRITE, r & ~32'h1800);
      step(1'b0, 1'b0, MSTATUS, 2'b00, 32'h0, 1'b0, 1'b1, 1'b0);
      for (int j = 0; j < 5; j++) begin
        r = $urandom;
        access(trap_addrs[r[10:8] % 7], r[1:0], $urandom);
        check_val("priv_lvl_o", 32'(U), 32'(priv_lvl_o));
        check_val("illegal_csr_insn_o", 32'h1, 32'(illegal_csr_insn_o));
      end
      step(1'b0, 1'b0, MTVAL, 2'b00, 32'h0, 1'b1, 1'b0, 1'b0);
      access(MTVAL, READ, 32'h0);
      check_val("priv_lvl_o", 32'(M), 32'(priv_lvl_o));
    end

    // interrupt enables against random inputs
    for (int i = 0; i < 100; i++) begin
      access(MIE, WRITE, $urandom);
      access(MIP, READ, 32'h0);
    end

    // counters
    access(MCOUNTINHIBIT, WRITE, 32'hFFFF_FFFF);
    access(MCOUNTINHIBIT, READ, 32'h0);
    check_val("mcountinhibit", 32'h5, csr_rdata_o);
    access(MCYCLE, READ, 32'h0);
    v0 = csr_rdata_o;
    access(MINSTRET, READ, 32'h0);
    v1 = csr_rdata_o;
    repeat (5) idle(MCYCLE, 1'b1);
    check_val("mcycle", v0, csr_rdata_o);
    access(MINSTRET, READ, 32'h0);
    check_val("minstret", v1, csr_rdata_o);
    access(MCOUNTINHIBIT, WRITE, 32'h0);
    for (int i = 0; i < 20; i++) begin
      access(MCYCLE, WRITE, $urandom);
      access(MCYCLEH, WRITE, $urandom);
      access(MINSTRET, WRITE, $urandom);
      access(MINSTRETH, WRITE, $urandom);
      access(MCYCLEH, READ, 32'h0);
      access(MINSTRETH, READ, 32'h0);
      k = $urandom_range(12, 3);
      access(MCYCLE, READ, 32'h0);
      v0 = csr_rdata_o;
      repeat (k) idle(MCYCLE, 1'b0);
      check_val("mcycle", v0 + 32'(k), csr_rdata_o);
      access(MINSTRET, READ, 32'h0);
      v0 = csr_rdata_o;
      rets = 0;
      for (int j = 1; j < k; j++) begin
        r = $urandom;
        rets += int'(r[0]);
        idle(MINSTRET, r[0]);
      end
      idle(MINSTRET, 1'b0);
      check_val("minstret", v0 + 32'(rets), csr_rdata_o);
    end

    $display("*** TEST PASSED ***");
    $finish;
  end

endmodule

//--- source/csr_file.sv
// --------------------------------------------------------------------
// machine-mode CSR file, top level
// access controller plus trap, interrupt and counter blocks
// --------------------------------------------------------------------
`timescale 1ns/1ns

module csr_file (
  input  logic                             clk_i,
  input  logic                             rst_ni,
  input  logic [csr_pkg::XLEN-1:0]         hart_id_i,
  input  logic [csr_pkg::XLEN-1:0]         boot_addr_i,
  input  logic                             csr_mtvec_init_i,

  // single-cycle access port
  input  logic                             csr_access_i,
  input  logic                             instr_new_i,
  input  csr_pkg::csr_addr_e               csr_addr_i,
  input  csr_pkg::csr_op_e                 csr_op_i,
  input  logic [csr_pkg::XLEN-1:0]         csr_wdata_i,
  output logic [csr_pkg::XLEN-1:0]         csr_rdata_o,
  output logic                             illegal_csr_insn_o,

  // trap control
  input  logic                             csr_save_cause_i,
  input  logic                             csr_restore_mret_i,
  input  logic [csr_pkg::XLEN-1:0]         pc_id_i,
  input  logic [csr_pkg::MCAUSE_W-1:0]     csr_mcause_i,
  input  logic [csr_pkg::XLEN-1:0]         csr_mtval_i,
  output csr_pkg::priv_lvl_e               priv_lvl_o,
  output logic                             csr_mstatus_mie_o,
  output logic                             csr_mstatus_tw_o,
  output logic [csr_pkg::XLEN-1:0]         csr_mepc_o,
  output logic [csr_pkg::XLEN-1:0]         csr_mtvec_o,

  // interrupts
  input  logic                             irq_software_i,
  input  logic                             irq_timer_i,
  input  logic                             irq_external_i,
  input  logic [csr_pkg::NUM_FAST_IRQ-1:0] irq_fast_i,
  output logic                             csr_msip_o,
  output logic                             csr_mtip_o,
  output logic                             csr_meip_o,
  output logic [csr_pkg::NUM_FAST_IRQ-1:0] csr_mfip_o,
  output logic                             irq_pending_o,

  input  logic                             instr_ret_i
);

  import csr_pkg::*;

  logic [XLEN-1:0] wdata;
  logic            we;
  logic [XLEN-1:0] trap_rdata, irq_rdata, cnt_rdata;
  logic            trap_hit, irq_hit, cnt_hit;

  csr_access_ctrl i_access_ctrl (
    .csr_access_i (csr_access_i),
    .instr_new_i  (instr_new_i),
    .csr_addr_i   (csr_addr_i),
    .csr_op_i     (csr_op_i),
    .csr_wdata_i  (csr_wdata_i),
    .priv_lvl_i   (priv_lvl_o),
    .trap_rdata_i (trap_rdata),
    .trap_hit_i   (trap_hit),
    .irq_rdata_i  (irq_rdata),
    .irq_hit_i    (irq_hit),
    .cnt_rdata_i  (cnt_rdata),
    .cnt_hit_i    (cnt_hit),
    .csr_rdata_o  (csr_rdata_o),
    .wdata_o      (wdata),
    .we_o         (we),
    .illegal_o    (illegal_csr_insn_o)
  );

  csr_trap_regs i_trap_regs (
    .clk_i              (clk_i),
    .rst_ni             (rst_ni),
    .csr_addr_i         (csr_addr_i),
    .wdata_i            (wdata),
    .we_i               (we),
    .hart_id_i          (hart_id_i),
    .boot_addr_i        (boot_addr_i),
    .csr_mtvec_init_i   (csr_mtvec_init_i),
    .csr_save_cause_i   (csr_save_cause_i),
    .csr_restore_mret_i (csr_restore_mret_i),
    .pc_i               (pc_id_i),
    .mcause_i           (csr_mcause_i),
    .mtval_i            (csr_mtval_i),
    .rdata_o            (trap_rdata),
    .hit_o              (trap_hit),
    .priv_lvl_o         (priv_lvl_o),
    .csr_mstatus_mie_o  (csr_mstatus_mie_o),
    .csr_mstatus_tw_o   (csr_mstatus_tw_o),
    .csr_mepc_o         (csr_mepc_o),
    .csr_mtvec_o        (csr_mtvec_o)
  );

  csr_irq_regs i_irq_regs (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .csr_addr_i     (csr_addr_i),
    .wdata_i        (wdata),
    .we_i           (we),
    .irq_software_i (irq_software_i),
    .irq_timer_i    (irq_timer_i),
    .irq_external_i (irq_external_i),
    .irq_fast_i     (irq_fast_i),
    .rdata_o        (irq_rdata),
    .hit_o          (irq_hit),
    .csr_msip_o     (csr_msip_o),
    .csr_mtip_o     (csr_mtip_o),
    .csr_meip_o     (csr_meip_o),
    .csr_mfip_o     (csr_mfip_o),
    .irq_pending_o  (irq_pending_o)
  );

  csr_counters i_counters (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .csr_addr_i  (csr_addr_i),
    .wdata_i     (wdata),
    .we_i        (we),
    .instr_ret_i (instr_ret_i),
    .rdata_o     (cnt_rdata),
    .hit_o       (cnt_hit)
  );

endmodule

//--- source/csr_counters.sv
// --------------------------------------------------------------------
// machine counters
// 64-bit mcycle and minstret under mcountinhibit
// --------------------------------------------------------------------
`timescale 1ns/1ns

module csr_counters (
  input  logic                     clk_i,
  input  logic                     rst_ni,
  input  csr_pkg::csr_addr_e       csr_addr_i,
  input  logic [csr_pkg::XLEN-1:0] wdata_i,
  input  logic                     we_i,
  input  logic                     instr_ret_i,
  output logic [csr_pkg::XLEN-1:0] rdata_o,
  output logic                     hit_o
);

  import csr_pkg::*;

  // index 0 is mcycle, 1 is minstret
  logic [63:0] cnt_q [2];
  logic [63:0] cnt_d [2];
  logic [1:0]  incr;
  logic [1:0]  wr_lo;
  logic [1:0]  wr_hi;
  logic [2:0]  inhibit_q;

  assign incr[0] = ~inhibit_q[0];
  assign incr[1] = instr_ret_i & ~inhibit_q[2];

  assign wr_lo[0] = we_i & (csr_addr_i == MCYCLE);
  assign wr_hi[0] = we_i & (csr_addr_i == MCYCLEH);
  assign wr_lo[1] = we_i & (csr_addr_i == MINSTRET);
  assign wr_hi[1] = we_i & (csr_addr_i == MINSTRETH);

  // a CSR write to either half replaces the increment
  always_comb begin
    for (int i = 0; i < 2; i++) begin
      if (wr_lo[i]) begin
        cnt_d[i] = {cnt_q[i][63:32], wdata_i};
      end else if (wr_hi[i]) begin
        cnt_d[i] = {wdata_i, cnt_q[i][31:0]};
      end else if (incr[i]) begin
        cnt_d[i] = cnt_q[i] + 64'd1;
      end else begin
        cnt_d[i] = cnt_q[i];
      end
    end
  end

  always_comb begin
    hit_o = 1'b1;
    case (csr_addr_i)
      MCYCLE:        rdata_o = cnt_q[0][31:0];
      MCYCLEH:       rdata_o = cnt_q[0][63:32];
      MINSTRET:      rdata_o = cnt_q[1][31:0];
      MINSTRETH:     rdata_o = cnt_q[1][63:32];
      MCOUNTINHIBIT: rdata_o = {{(XLEN-3){1'b0}}, inhibit_q};
      default: begin
        rdata_o = '0;
        hit_o   = 1'b0;
      end
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      cnt_q[0]  <= '0;
      cnt_q[1]  <= '0;
      inhibit_q <= '0;
    end else begin
      cnt_q[0] <= cnt_d[0];
      cnt_q[1] <= cnt_d[1];
      // bit 1 has no counter behind it
      if (we_i && (csr_addr_i == MCOUNTINHIBIT)) begin
        inhibit_q <= {wdata_i[2], 1'b0, wdata_i[0]};
      end
    end
  end

endmodule

//--- source/csr_irq_regs.sv
// --------------------------------------------------------------------
// interrupt enable and pending
// mie register, gated mip vector and the pending summary
// --------------------------------------------------------------------
`timescale 1ns/1ns

module csr_irq_regs (
  input  logic                             clk_i,
  input  logic                             rst_ni,
  input  csr_pkg::csr_addr_e               csr_addr_i,
  input  logic [csr_pkg::XLEN-1:0]         wdata_i,
  input  logic                             we_i,
  input  logic                             irq_software_i,
  input  logic                             irq_timer_i,
  input  logic                             irq_external_i,
  input  logic [csr_pkg::NUM_FAST_IRQ-1:0] irq_fast_i,
  output logic [csr_pkg::XLEN-1:0]         rdata_o,
  output logic                             hit_o,
  output logic                             csr_msip_o,
  output logic                             csr_mtip_o,
  output logic                             csr_meip_o,
  output logic [csr_pkg::NUM_FAST_IRQ-1:0] csr_mfip_o,
  output logic                             irq_pending_o
);

  import csr_pkg::*;

  localparam int unsigned FAST_HI = IRQ_FAST_LO + NUM_FAST_IRQ - 1;

  logic                    msie_q;
  logic                    mtie_q;
  logic                    meie_q;
  logic [NUM_FAST_IRQ-1:0] mfie_q;
  logic [XLEN-1:0]         irq_in;
  logic [XLEN-1:0]         mie_word;

  // both views share the same layout
  assign mie_word = {{(XLEN-1-FAST_HI){1'b0}}, mfie_q, {(IRQ_FAST_LO-IRQ_EXT_BIT-1){1'b0}},
                     meie_q, {(IRQ_EXT_BIT-IRQ_TIMER_BIT-1){1'b0}},
                     mtie_q, {(IRQ_TIMER_BIT-IRQ_SW_BIT-1){1'b0}},
                     msie_q, {IRQ_SW_BIT{1'b0}}};
  assign irq_in   = {{(XLEN-1-FAST_HI){1'b0}}, irq_fast_i, {(IRQ_FAST_LO-IRQ_EXT_BIT-1){1'b0}},
                     irq_external_i, {(IRQ_EXT_BIT-IRQ_TIMER_BIT-1){1'b0}},
                     irq_timer_i, {(IRQ_TIMER_BIT-IRQ_SW_BIT-1){1'b0}},
                     irq_software_i, {IRQ_SW_BIT{1'b0}}};

  // mip is pure logic so a sleeping core wakes without a clock
  assign csr_msip_o    = irq_software_i & msie_q;
  assign csr_mtip_o    = irq_timer_i & mtie_q;
  assign csr_meip_o    = irq_external_i & meie_q;
  assign csr_mfip_o    = irq_fast_i & mfie_q;
  assign irq_pending_o = csr_msip_o | csr_mtip_o | csr_meip_o | (|csr_mfip_o);

  always_comb begin
    hit_o   = 1'b1;
    rdata_o = '0;
    case (csr_addr_i)
      MIE:     rdata_o = mie_word;
      MIP:     rdata_o = mie_word & irq_in;
      default: hit_o   = 1'b0;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      msie_q <= 1'b0;
      mtie_q <= 1'b0;
      meie_q <= 1'b0;
      mfie_q <= '0;
    end else if (we_i && (csr_addr_i == MIE)) begin
      msie_q <= wdata_i[IRQ_SW_BIT];
      mtie_q <= wdata_i[IRQ_TIMER_BIT];
      meie_q <= wdata_i[IRQ_EXT_BIT];
      mfie_q <= wdata_i[FAST_HI:IRQ_FAST_LO];
    end
  end

endmodule

//--- source/csr_trap_regs.sv
// --------------------------------------------------------------------
// machine trap CSRs
// mstatus, mtvec, mepc, mcause, mtval, mscratch, misa and mhartid,
// with trap entry, MRET return and the current privilege level
// --------------------------------------------------------------------
`timescale 1ns/1ns

module csr_trap_regs (
  input  logic                         clk_i,
  input  logic                         rst_ni,
  input  csr_pkg::csr_addr_e           csr_addr_i,
  input  logic [csr_pkg::XLEN-1:0]     wdata_i,
  input  logic                         we_i,
  input  logic [csr_pkg::XLEN-1:0]     hart_id_i,
  input  logic [csr_pkg::XLEN-1:0]     boot_addr_i,
  input  logic                         csr_mtvec_init_i,
  input  logic                         csr_save_cause_i,
  input  logic                         csr_restore_mret_i,
  input  logic [csr_pkg::XLEN-1:0]     pc_i,
  input  logic [csr_pkg::MCAUSE_W-1:0] mcause_i,
  input  logic [csr_pkg::XLEN-1:0]     mtval_i,
  output logic [csr_pkg::XLEN-1:0]     rdata_o,
  output logic                         hit_o,
  output csr_pkg::priv_lvl_e           priv_lvl_o,
  output logic                         csr_mstatus_mie_o,
  output logic                         csr_mstatus_tw_o,
  output logic [csr_pkg::XLEN-1:0]     csr_mepc_o,
  output logic [csr_pkg::XLEN-1:0]     csr_mtvec_o
);

  import csr_pkg::*;

  priv_lvl_e             priv_q, priv_d;
  logic                  mie_q, mie_d;
  logic                  mpie_q, mpie_d;
  priv_lvl_e             mpp_q, mpp_d;
  logic                  tw_q, tw_d;
  logic [XLEN-1:0]       mscratch_q, mscratch_d;
  logic [XLEN-1:0]       mepc_q, mepc_d;
  logic [MCAUSE_W-1:0]   mcause_q, mcause_d;
  logic [XLEN-1:0]       mtval_q, mtval_d;
  logic [XLEN-1:0]       mtvec_q, mtvec_d;

  // ------------------------------------------------------------------
  // read side
  // ------------------------------------------------------------------
  always_comb begin
    rdata_o = '0;
    hit_o   = 1'b1;
    case (csr_addr_i)
      MSTATUS: begin
        rdata_o[MSTATUS_MIE_BIT]               = mie_q;
        rdata_o[MSTATUS_MPIE_BIT]              = mpie_q;
        rdata_o[MSTATUS_MPP_HI:MSTATUS_MPP_LO] = mpp_q;
        rdata_o[MSTATUS_TW_BIT]                = tw_q;
      end
      MISA:     rdata_o = MISA_VALUE;
      MTVEC:    rdata_o = mtvec_q;
      MSCRATCH: rdata_o = mscratch_q;
      MEPC:     rdata_o = mepc_q;
      // interrupt flag on top, code in the low bits
      MCAUSE:   rdata_o = {mcause_q[MCAUSE_W-1], {(XLEN-MCAUSE_W){1'b0}},
                           mcause_q[MCAUSE_W-2:0]};
      MTVAL:    rdata_o = mtval_q;
      MHARTID:  rdata_o = hart_id_i;
      default:  hit_o   = 1'b0;
    endcase
  end

  // ------------------------------------------------------------------
  // next state
  // ------------------------------------------------------------------
  always_comb begin
    priv_d     = priv_q;
    mie_d      = mie_q;
    mpie_d     = mpie_q;
    mpp_d      = mpp_q;
    tw_d       = tw_q;
    mscratch_d = mscratch_q;
    mepc_d     = mepc_q;
    mcause_d   = mcause_q;
    mtval_d    = mtval_q;
    mtvec_d    = csr_mtvec_init_i ?
                 {boot_addr_i[XLEN-1:MTVEC_ALIGN], {(MTVEC_ALIGN-2){1'b0}}, 2'b01} : mtvec_q;

    if (we_i) begin
      case (csr_addr_i)
        MSTATUS: begin
          mie_d  = wdata_i[MSTATUS_MIE_BIT];
          mpie_d = wdata_i[MSTATUS_MPIE_BIT];
          // unsupported levels fall back to M
          mpp_d  = (wdata_i[MSTATUS_MPP_HI:MSTATUS_MPP_LO] == U) ? U : M;
          tw_d   = wdata_i[MSTATUS_TW_BIT];
        end
        MSCRATCH: mscratch_d = wdata_i;
        MEPC:     mepc_d     = {wdata_i[XLEN-1:1], 1'b0};
        MCAUSE:   mcause_d   = {wdata_i[XLEN-1], wdata_i[MCAUSE_W-2:0]};
        MTVAL:    mtval_d    = wdata_i;
        // base 256-byte aligned, mode always vectored
        MTVEC:    mtvec_d    = {wdata_i[XLEN-1:MTVEC_ALIGN], {(MTVEC_ALIGN-2){1'b0}}, 2'b01};
        default: ;
      endcase
    end

    // trap entry overrides a CSR write in the same cycle
    if (csr_save_cause_i) begin
      priv_d   = M;
      mpie_d   = mie_q;
      mpp_d    = priv_q;
      mie_d    = 1'b0;
      mepc_d   = pc_i;
      mcause_d = mcause_i;
      mtval_d  = mtval_i;
    end else if (csr_restore_mret_i) begin
      priv_d = mpp_q;
      mie_d  = mpie_q;
      mpie_d = 1'b1;
      mpp_d  = U;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      priv_q     <= M;
      mie_q      <= 1'b0;
      mpie_q     <= 1'b1;
      mpp_q      <= U;
      tw_q       <= 1'b0;
      mscratch_q <= '0;
      mepc_q     <= '0;
      mcause_q   <= '0;
      mtval_q    <= '0;
      mtvec_q    <= 32'd1;
    end else begin
      priv_q     <= priv_d;
      mie_q      <= mie_d;
      mpie_q     <= mpie_d;
      mpp_q      <= mpp_d;
      tw_q       <= tw_d;
      mscratch_q <= mscratch_d;
      mepc_q     <= mepc_d;
      mcause_q   <= mcause_d;
      mtval_q    <= mtval_d;
      mtvec_q    <= mtvec_d;
    end
  end

  assign priv_lvl_o        = priv_q;
  assign csr_mstatus_mie_o = mie_q;
  assign csr_mstatus_tw_o  = tw_q;
  assign csr_mepc_o        = mepc_q;
  assign csr_mtvec_o       = mtvec_q;

endmodule

//--- source/csr_access_ctrl.sv
// --------------------------------------------------------------------
// CSR access controller
// read data select, write data merge and the legality check
// --------------------------------------------------------------------
`timescale 1ns/1ns

module csr_access_ctrl (
  input  logic                     csr_access_i,
  input  logic                     instr_new_i,
  input  csr_pkg::csr_addr_e       csr_addr_i,
  input  csr_pkg::csr_op_e         csr_op_i,
  input  logic [csr_pkg::XLEN-1:0] csr_wdata_i,
  input  csr_pkg::priv_lvl_e       priv_lvl_i,

  input  logic [csr_pkg::XLEN-1:0] trap_rdata_i,
  input  logic                     trap_hit_i,
  input  logic [csr_pkg::XLEN-1:0] irq_rdata_i,
  input  logic                     irq_hit_i,
  input  logic [csr_pkg::XLEN-1:0] cnt_rdata_i,
  input  logic                     cnt_hit_i,

  output logic [csr_pkg::XLEN-1:0] csr_rdata_o,
  output logic [csr_pkg::XLEN-1:0] wdata_o,
  output logic                     we_o,
  output logic                     illegal_o
);

  import csr_pkg::*;

  logic [11:0] addr;
  logic        wreq;
  logic        no_hit;
  logic        priv_err;
  logic        ro_err;

  assign addr = csr_addr_i;

  // ------------------------------------------------------------------
  // read select
  // ------------------------------------------------------------------
  // at most one block claims an address
  assign csr_rdata_o = ({XLEN{trap_hit_i}} & trap_rdata_i)
                     | ({XLEN{irq_hit_i}}  & irq_rdata_i)
                     | ({XLEN{cnt_hit_i}}  & cnt_rdata_i);

  // read-modify-write against the current value
  always_comb begin
    case (csr_op_i)
      WRITE:   wdata_o = csr_wdata_i;
      SET:     wdata_o = csr_wdata_i | csr_rdata_o;
      CLEAR:   wdata_o = ~csr_wdata_i & csr_rdata_o;
      default: wdata_o = csr_wdata_i;
    endcase
  end

  // ------------------------------------------------------------------
  // legality
  // ------------------------------------------------------------------
  assign wreq     = (csr_op_i != READ);
  assign no_hit   = ~(trap_hit_i | irq_hit_i | cnt_hit_i);
  // address bits 9:8 give the lowest privilege allowed
  assign priv_err = (addr[9:8] > priv_lvl_i);
  // 11:10 == 3 marks a read-only CSR
  assign ro_err   = (addr[11:10] == 2'b11) & wreq;

  assign illegal_o = csr_access_i & (no_hit | priv_err | ro_err);

  // one write per instruction
  assign we_o = csr_access_i & instr_new_i & wreq & ~illegal_o;

endmodule

//--- source/csr_pkg.sv
// --------------------------------------------------------------------
// CSR file package
// addresses, operations, privilege levels and machine field positions
// --------------------------------------------------------------------
package csr_pkg;

  // data and field widths
  localparam int unsigned XLEN         = 32;
  localparam int unsigned NUM_FAST_IRQ = 15;
  localparam int unsigned MCAUSE_W     = 6;
  localparam int unsigned MTVEC_ALIGN  = 8;

  // machine-mode CSR addresses
  typedef enum logic [11:0] {
    MSTATUS       = 12'h300,
    MISA          = 12'h301,
    MIE           = 12'h304,
    MTVEC         = 12'h305,
    MCOUNTINHIBIT = 12'h320,
    MSCRATCH      = 12'h340,
    MEPC          = 12'h341,
    MCAUSE        = 12'h342,
    MTVAL         = 12'h343,
    MIP           = 12'h344,
    MCYCLE        = 12'hB00,
    MINSTRET      = 12'hB02,
    MCYCLEH       = 12'hB80,
    MINSTRETH     = 12'hB82,
    MHARTID       = 12'hF14
  } csr_addr_e;

  typedef enum logic [1:0] {
    READ  = 2'b00,
    WRITE = 2'b01,
    SET   = 2'b10,
    CLEAR = 2'b11
  } csr_op_e;

  typedef enum logic [1:0] {
    U = 2'b00,
    M = 2'b11
  } priv_lvl_e;

  // mstatus fields
  localparam int unsigned MSTATUS_MIE_BIT  = 3;
  localparam int unsigned MSTATUS_MPIE_BIT = 7;
  localparam int unsigned MSTATUS_MPP_LO   = 11;
  localparam int unsigned MSTATUS_MPP_HI   = 12;
  localparam int unsigned MSTATUS_TW_BIT   = 21;

  // mie / mip positions, fast irqs sit at 16 and up
  localparam int unsigned IRQ_SW_BIT    = 3;
  localparam int unsigned IRQ_TIMER_BIT = 7;
  localparam int unsigned IRQ_EXT_BIT   = 11;
  localparam int unsigned IRQ_FAST_LO   = 16;

  // RV32IMC, MXL = 1
  localparam logic [XLEN-1:0] MISA_VALUE = (32'd1 << 30)  // mxl
                                         | (32'd1 << 12)  // M
                                         | (32'd1 << 8)   // I
                                         | (32'd1 << 2);  // C

endpackage
